//--- key_extract_defines.svh
`ifndef KEY_EXTRACT_DEFINES_SVH
`define KEY_EXTRACT_DEFINES_SVH

// container classes, eight of each
`define KE_NUM_CONT     8
`define KE_W6           48
`define KE_W4           32
`define KE_W2           16

// phv layout, metadata sits at the bottom
`define KE_META_W       256
`define KE_PHV_W        1024
`define KE_TENANT_LSB   133

// key and table entries
`define KE_KEY_W        193
`define KE_OP_W         20
`define KE_OFF_W        38
`define KE_TBL_DEPTH    16

// wishbone slave and its address map
`define KE_WB_AW        9
`define KE_WB_DW        32
`define KE_ADR_TBL_BIT  8
`define KE_ADR_IDX_LSB  4
`define KE_ADR_WORD_W   3
`define KE_MASK_WORDS   7
`define KE_OFF_WORDS    2

`endif

//--- key_extract_pkg.sv
`include "key_extract_defines.svh"

package key_extract_pkg;

    typedef logic [`KE_W6-1:0] cont6_t;
    typedef logic [`KE_W4-1:0] cont4_t;
    typedef logic [`KE_W2-1:0] cont2_t;

    // containers 7 down to 0 in each class, msb first
    typedef struct packed {
        cont6_t [`KE_NUM_CONT-1:0] c6;
        cont4_t [`KE_NUM_CONT-1:0] c4;
        cont2_t [`KE_NUM_CONT-1:0] c2;
        logic [`KE_META_W-1:0]     meta;
    } phv_t;

    typedef struct packed {
        cont6_t f6_a;
        cont6_t f6_b;
        cont4_t f4_a;
        cont4_t f4_b;
        cont2_t f2_a;
        cont2_t f2_b;
        logic   cmp;
    } key_t;

    typedef key_t mask_entry_t;

    typedef logic [$clog2(`KE_TBL_DEPTH)-1:0] tenant_t;
    typedef logic [$clog2(`KE_NUM_CONT)-1:0] sel_t;
    typedef logic [7:0] op_byte_t;

    typedef enum logic [1:0] {OP_GT, OP_GE, OP_EQ, OP_TRUE} cmp_opcode_t;
    typedef enum logic [1:0] {CLS_2B, CLS_4B, CLS_6B, CLS_ZERO} cont_class_t;

    // val is the immediate, or {3'b0, class, index} when is_imm is low
    typedef struct packed {
        logic     is_imm;
        op_byte_t val;
    } cmp_operand_t;

    typedef struct packed {
        cmp_opcode_t  opcode;
        cmp_operand_t opa;
        cmp_operand_t opb;
    } cmp_op_t;

    typedef struct packed {
        sel_t    sel6_a;
        sel_t    sel6_b;
        sel_t    sel4_a;
        sel_t    sel4_b;
        sel_t    sel2_a;
        sel_t    sel2_b;
        cmp_op_t op;
    } off_entry_t;

endpackage

//--- key_extract_if.sv
`timescale 1ns/1ps

// one-cycle table write, data and index valid with the enable
interface tbl_wr_if import key_extract_pkg::*; ();
    logic        off_we;
    logic        mask_we;
    tenant_t     index;
    off_entry_t  off_entry;
    mask_entry_t mask_entry;

    modport source (output off_we, mask_we, index, off_entry, mask_entry);
endinterface

// stage strobes from the sequencer to the datapath
interface stage_ctrl_if;
    logic capture;
    logic latch_entry;
    logic select_ops;
    logic build;

    modport ctrl (output capture, latch_entry, select_ops, build);
    modport dp (input capture, latch_entry, select_ops, build);
endinterface

//--- table_ram.sv
`timescale 1ns/1ps
`include "key_extract_defines.svh"

module table_ram import key_extract_pkg::*; #(
    parameter type entry_t = off_entry_t
) (
    input  logic    clk,
    input  logic    we,
    input  tenant_t wr_index,
    input  entry_t  wr_data,
    input  tenant_t rd_index,
    output entry_t  rd_data
);

    entry_t mem [`KE_TBL_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_index] <= wr_data;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_index];
    end

endmodule

//--- wb_table_port.sv
`timescale 1ns/1ps
`include "key_extract_defines.svh"

module wb_table_port import key_extract_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [`KE_WB_AW-1:0] wb_adr,
    input  logic [`KE_WB_DW-1:0] wb_dat_w,
    output logic [`KE_WB_DW-1:0] wb_dat_r,
    output logic                 wb_ack,
    tbl_wr_if.source             wr
);

    logic                                 wr_req;
    logic                                 sel_mask;
    logic [`KE_ADR_WORD_W-1:0]            word;
    logic [`KE_OFF_WORDS*`KE_WB_DW-1:0]   off_stage;
    logic [`KE_MASK_WORDS*`KE_WB_DW-1:0]  mask_stage;

    // hold off a second write while the ack is still out
    assign wr_req   = wb_cyc && wb_stb && wb_we && !wb_ack;
    assign sel_mask = wb_adr[`KE_ADR_TBL_BIT];
    assign word     = wb_adr[`KE_ADR_WORD_W-1:0];

    // tables are write only
    assign wb_dat_r = '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack     <= 1'b0;
            wr.off_we  <= 1'b0;
            wr.mask_we <= 1'b0;
        end else begin
            wb_ack     <= wb_cyc && wb_stb && !wb_ack;
            wr.off_we  <= wr_req && !sel_mask &&
                          (word == `KE_ADR_WORD_W'(`KE_OFF_WORDS - 1));
            wr.mask_we <= wr_req && sel_mask &&
                          (word == `KE_ADR_WORD_W'(`KE_MASK_WORDS - 1));
        end
    end

    // word 0 is the least significant
    always_ff @(posedge clk) begin
        if (wr_req) begin
            wr.index <= wb_adr[`KE_ADR_IDX_LSB +: $bits(tenant_t)];
            if (sel_mask && word < `KE_ADR_WORD_W'(`KE_MASK_WORDS)) begin
                mask_stage[word*`KE_WB_DW +: `KE_WB_DW] <= wb_dat_w;
            end
            if (!sel_mask && word < `KE_ADR_WORD_W'(`KE_OFF_WORDS)) begin
                off_stage[word*`KE_WB_DW +: `KE_WB_DW] <= wb_dat_w;
            end
        end
    end

    assign wr.off_entry  = off_entry_t'(off_stage[`KE_OFF_W-1:0]);
    assign wr.mask_entry = mask_entry_t'(mask_stage[`KE_KEY_W-1:0]);

endmodule

//--- key_extract_fsm.sv
`timescale 1ns/1ps

module key_extract_fsm (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       phv_valid_in,
    input  logic       ready_in,
    output logic       ready_out,
    output logic       phv_valid_out,
    output logic       key_valid_out,
    stage_ctrl_if.ctrl ctl
);

    typedef enum logic [2:0] {
        IDLE,
        READ,
        LATCH,
        SELECT,
        BUILD,
        HOLD
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   accept;
    logic   handoff;
    logic   out_valid;

    assign accept  = (state == IDLE) && phv_valid_in && ready_out;
    assign handoff = (state == HOLD) && ready_in;

    // READ waits out the table read latency
    assign ctl.capture     = accept;
    assign ctl.latch_entry = (state == LATCH);
    assign ctl.select_ops  = (state == SELECT);
    assign ctl.build       = (state == BUILD);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_nxt = READ;
                end
            end
            READ:   state_nxt = LATCH;
            LATCH:  state_nxt = SELECT;
            SELECT: state_nxt = BUILD;
            BUILD:  state_nxt = HOLD;
            HOLD: begin
                if (ready_in) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            ready_out <= 1'b1;
            out_valid <= 1'b0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                ready_out <= 1'b0;
            end else if (handoff) begin
                ready_out <= 1'b1;
            end
            // valids come up with the built outputs
            if (state == BUILD) begin
                out_valid <= 1'b1;
            end else if (handoff) begin
                out_valid <= 1'b0;
            end
        end
    end

    assign phv_valid_out = out_valid;
    assign key_valid_out = out_valid;

endmodule

//--- key_builder.sv
`timescale 1ns/1ps
`include "key_extract_defines.svh"

module key_builder import key_extract_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    stage_ctrl_if.dp    dp,
    input  phv_t        phv_in,
    output tenant_t     tenant,
    input  off_entry_t  off_rd,
    input  mask_entry_t mask_rd,
    output phv_t        phv_out,
    output key_t        key_out_masked,
    output key_t        key_mask_out
);

    phv_t        phv_q;
    off_entry_t  off_q;
    mask_entry_t mask_q;
    op_byte_t    opa_q;
    op_byte_t    opb_q;
    key_t        key_c;

    // low byte of a container, or the immediate
    function automatic op_byte_t pick_operand(input cmp_operand_t opnd, input phv_t p);
        cont_class_t cls;
        sel_t        idx;
        op_byte_t    res;
        cls = cont_class_t'(opnd.val[4:3]);
        idx = opnd.val[2:0];
        if (opnd.is_imm) begin
            res = opnd.val;
        end else begin
            case (cls)
                CLS_6B:  res = p.c6[idx][7:0];
                CLS_4B:  res = p.c4[idx][7:0];
                CLS_2B:  res = p.c2[idx][7:0];
                default: res = '0;
            endcase
        end
        return res;
    endfunction

    // containers are read straight out of the captured phv
    always_ff @(posedge clk) begin
        if (dp.capture) begin
            phv_q <= phv_in;
        end
    end

    assign tenant = phv_q[`KE_TENANT_LSB +: $bits(tenant_t)];

    always_ff @(posedge clk) begin
        if (dp.latch_entry) begin
            off_q  <= off_rd;
            mask_q <= mask_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (dp.select_ops) begin
            opa_q <= pick_operand(off_q.op.opa, phv_q);
            opb_q <= pick_operand(off_q.op.opb, phv_q);
        end
    end

    always_comb begin
        key_c.f6_a = phv_q.c6[off_q.sel6_a];
        key_c.f6_b = phv_q.c6[off_q.sel6_b];
        key_c.f4_a = phv_q.c4[off_q.sel4_a];
        key_c.f4_b = phv_q.c4[off_q.sel4_b];
        key_c.f2_a = phv_q.c2[off_q.sel2_a];
        key_c.f2_b = phv_q.c2[off_q.sel2_b];
        // unsigned byte compare
        case (off_q.op.opcode)
            OP_GT:   key_c.cmp = (opa_q > opb_q);
            OP_GE:   key_c.cmp = (opa_q >= opb_q);
            OP_EQ:   key_c.cmp = (opa_q == opb_q);
            default: key_c.cmp = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phv_out        <= '0;
            key_out_masked <= '0;
            key_mask_out   <= '0;
        end else if (dp.build) begin
            phv_out        <= phv_q;
            // a set mask bit clears the key bit
            key_out_masked <= key_t'(key_c & ~mask_q);
            key_mask_out   <= mask_q;
        end
    end

endmodule

//--- key_extract.sv
`timescale 1ns/1ps
`include "key_extract_defines.svh"

module key_extract import key_extract_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  phv_t                 phv_in,
    input  logic                 phv_valid_in,
    output logic                 ready_out,
    output phv_t                 phv_out,
    output logic                 phv_valid_out,
    output key_t                 key_out_masked,
    output key_t                 key_mask_out,
    output logic                 key_valid_out,
    input  logic                 ready_in,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [`KE_WB_AW-1:0] wb_adr,
    input  logic [`KE_WB_DW-1:0] wb_dat_w,
    output logic [`KE_WB_DW-1:0] wb_dat_r,
    output logic                 wb_ack
);

    tenant_t     tenant;
    off_entry_t  off_rd;
    mask_entry_t mask_rd;

    tbl_wr_if     wr ();
    stage_ctrl_if ctl ();

    wb_table_port u_wb_port (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wr       (wr.source)
    );

    // both tables are indexed by the captured tenant
    table_ram #(.entry_t(off_entry_t)) u_off_ram (
        .clk      (clk),
        .we       (wr.off_we),
        .wr_index (wr.index),
        .wr_data  (wr.off_entry),
        .rd_index (tenant),
        .rd_data  (off_rd)
    );

    table_ram #(.entry_t(mask_entry_t)) u_mask_ram (
        .clk      (clk),
        .we       (wr.mask_we),
        .wr_index (wr.index),
        .wr_data  (wr.mask_entry),
        .rd_index (tenant),
        .rd_data  (mask_rd)
    );

    key_extract_fsm u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_valid_in  (phv_valid_in),
        .ready_in      (ready_in),
        .ready_out     (ready_out),
        .phv_valid_out (phv_valid_out),
        .key_valid_out (key_valid_out),
        .ctl           (ctl.ctrl)
    );

    key_builder u_builder (
        .clk            (clk),
        .rst_n          (rst_n),
        .dp             (ctl.dp),
        .phv_in         (phv_in),
        .tenant         (tenant),
        .off_rd         (off_rd),
        .mask_rd        (mask_rd),
        .phv_out        (phv_out),
        .key_out_masked (key_out_masked),
        .key_mask_out   (key_mask_out)
    );

endmodule

//--- key_extract_checker.sv
`timescale 1ns/1ps
`include "key_extract_defines.svh"

module key_extract_checker import key_extract_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  phv_t                          phv_in,
    input  logic                          phv_valid_in,
    input  logic                          ready_out,
    input  phv_t                          phv_out,
    input  logic                          phv_valid_out,
    input  key_t                          key_out_masked,
    input  key_t                          key_mask_out,
    input  logic                          key_valid_out,
    input  logic                          ready_in,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic                          wb_ack,
    input  logic [`KE_WB_DW-1:0]          wb_dat_r,
    input  off_entry_t  [`KE_TBL_DEPTH-1:0] off_shadow,
    input  mask_entry_t [`KE_TBL_DEPTH-1:0] mask_shadow,
    output int                            mismatches,
    output int                            protocol_errs,
    output int                            checked
);

    localparam int C2_LSB = `KE_META_W;
    localparam int C4_LSB = C2_LSB + `KE_NUM_CONT * `KE_W2;
    localparam int C6_LSB = C4_LSB + `KE_NUM_CONT * `KE_W4;

    int                      mism_cnt = 0;
    int                      proto_cnt = 0;
    int                      check_cnt = 0;
    bit                      pending = 0;
    bit                      handoff_due = 0;
    bit                      prev_req = 0;
    bit                      prev_rd = 0;
    bit                      prev_ack = 0;
    int                      age;
    logic [`KE_PHV_W-1:0]    exp_phv;
    logic [`KE_KEY_W-1:0]    exp_key;
    logic [`KE_KEY_W-1:0]    exp_mask;

    assign mismatches    = mism_cnt;
    assign protocol_errs = proto_cnt;
    assign checked       = check_cnt;

    function automatic logic [`KE_W6-1:0] c6(input logic [`KE_PHV_W-1:0] p, input int i);
        return p[C6_LSB + `KE_W6 * i +: `KE_W6];
    endfunction

    function automatic logic [`KE_W4-1:0] c4(input logic [`KE_PHV_W-1:0] p, input int i);
        return p[C4_LSB + `KE_W4 * i +: `KE_W4];
    endfunction

    function automatic logic [`KE_W2-1:0] c2(input logic [`KE_PHV_W-1:0] p, input int i);
        return p[C2_LSB + `KE_W2 * i +: `KE_W2];
    endfunction

    // operand is {imm flag, imm byte} or {0, 3'b0, class, index}
    function automatic logic [7:0] operand_byte(input logic [8:0] opnd,
                                                input logic [`KE_PHV_W-1:0] p);
        logic [7:0] b;
        if (opnd[8]) begin
            b = opnd[7:0];
        end else begin
            case (opnd[4:3])
                2'd2:    b = 8'(c6(p, int'(opnd[2:0])));
                2'd1:    b = 8'(c4(p, int'(opnd[2:0])));
                2'd0:    b = 8'(c2(p, int'(opnd[2:0])));
                default: b = 8'h00;
            endcase
        end
        return b;
    endfunction

    function automatic logic [`KE_KEY_W-1:0] expected_key(input logic [`KE_PHV_W-1:0] p,
                                                          input logic [`KE_OFF_W-1:0] ent,
                                                          input logic [`KE_KEY_W-1:0] mask);
        logic [7:0]           a;
        logic [7:0]           b;
        logic                 cmp;
        logic [`KE_KEY_W-1:0] key;
        a = operand_byte(ent[17:9], p);
        b = operand_byte(ent[8:0], p);
        case (ent[19:18])
            2'd0:    cmp = (a > b);
            2'd1:    cmp = (a >= b);
            2'd2:    cmp = (a == b);
            default: cmp = 1'b1;
        endcase
        key = {c6(p, int'(ent[37:35])), c6(p, int'(ent[34:32])),
               c4(p, int'(ent[31:29])), c4(p, int'(ent[28:26])),
               c2(p, int'(ent[25:23])), c2(p, int'(ent[22:20])), cmp};
        return key & ~mask;
    endfunction

    task automatic protocol_error(input string msg);
        $display("protocol error at %0t: %s", $time, msg);
        proto_cnt++;
    endtask

    // outputs move on rising edges, so look at them on the falling edge
    always @(negedge clk) begin
        logic [3:0] tn;
        if (!rst_n) begin
            if (ready_out !== 1'b1 || phv_valid_out !== 1'b0 ||
                key_valid_out !== 1'b0 || wb_ack !== 1'b0) begin
                protocol_error("outputs not at their reset values during reset");
            end
            pending     = 0;
            handoff_due = 0;
            prev_req    = 0;
            prev_rd     = 0;
            prev_ack    = 0;
        end else begin
            // ack exactly one cycle after a strobe, never twice in a row
            if (wb_ack !== (prev_req && !prev_ack)) begin
                protocol_error("wb_ack not a single cycle after the strobe");
            end
            // tables are write only, a read returns zero
            if (wb_ack === 1'b1 && prev_rd && wb_dat_r !== '0) begin
                $display("mismatch at %0t: wb_dat_r %h on a read, expected zero",
                         $time, wb_dat_r);
                mism_cnt++;
            end
            prev_req = wb_cyc && wb_stb;
            prev_rd  = wb_cyc && wb_stb && !wb_we;
            prev_ack = wb_ack;
            if (phv_valid_out !== key_valid_out) begin
                protocol_error("phv_valid_out and key_valid_out differ");
            end
            if (handoff_due) begin
                if (phv_valid_out !== 1'b0 || ready_out !== 1'b1) begin
                    protocol_error("no handoff at the edge with ready_in high");
                end
                handoff_due = 0;
            end else if (pending) begin
                age++;
                if (ready_out !== 1'b0) begin
                    protocol_error("ready_out high while a PHV is in flight");
                end
                if (age < 5) begin
                    if (phv_valid_out !== 1'b0) begin
                        protocol_error("valids rose before four edges after accept");
                    end
                end else if (phv_valid_out !== 1'b1) begin
                    protocol_error("valids not up four edges after accept");
                    pending = 0;
                end else begin
                    if (age == 5) begin
                        check_cnt++;
                    end
                    if (phv_out !== exp_phv) begin
                        $display("mismatch at %0t: phv_out differs from accepted PHV", $time);
                        mism_cnt++;
                    end
                    if (key_out_masked !== exp_key) begin
                        $display("mismatch at %0t: key_out_masked %h expected %h",
                                 $time, key_out_masked, exp_key);
                        mism_cnt++;
                    end
                    if (key_mask_out !== exp_mask) begin
                        $display("mismatch at %0t: key_mask_out %h expected %h",
                                 $time, key_mask_out, exp_mask);
                        mism_cnt++;
                    end
                    if (ready_in === 1'b1) begin
                        handoff_due = 1;
                        pending     = 0;
                    end
                end
            end else begin
                if (phv_valid_out !== 1'b0) begin
                    protocol_error("valid high with nothing in flight");
                end
                if (ready_out !== 1'b1) begin
                    protocol_error("ready_out low while idle");
                end
            end
            if (!pending && !handoff_due && phv_valid_in === 1'b1 && ready_out === 1'b1) begin
                exp_phv  = phv_in;
                tn       = exp_phv[`KE_TENANT_LSB +: 4];
                exp_mask = mask_shadow[tn];
                exp_key  = expected_key(exp_phv, off_shadow[tn], exp_mask);
                pending  = 1;
                age      = 0;
            end
        end
    end

endmodule

//--- tb_key_extract.sv
`timescale 1ns/1ps
`include "key_extract_defines.svh"

module tb_key_extract import key_extract_pkg::*; ();

    localparam int ACK_LIMIT    = 8;
    localparam int ACCEPT_LIMIT = 16;
    localparam int VALID_LIMIT  = 10;
    localparam int ITEMS        = 48;

    logic                 clk;
    logic                 rst_n;
    phv_t                 phv_in;
    logic                 phv_valid_in;
    logic                 ready_out;
    phv_t                 phv_out;
    logic                 phv_valid_out;
    key_t                 key_out_masked;
    key_t                 key_mask_out;
    logic                 key_valid_out;
    logic                 ready_in;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [`KE_WB_AW-1:0] wb_adr;
    logic [`KE_WB_DW-1:0] wb_dat_w;
    logic [`KE_WB_DW-1:0] wb_dat_r;
    logic                 wb_ack;

    off_entry_t  [`KE_TBL_DEPTH-1:0] off_shadow;
    mask_entry_t [`KE_TBL_DEPTH-1:0] mask_shadow;
    int          mismatches;
    int          protocol_errs;
    int          checked;
    int          timeouts = 0;
    bit          timed_out = 0;
    logic [31:0] lfsr = 32'hfbe8_c9f7;

    key_extract u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .phv_in         (phv_in),
        .phv_valid_in   (phv_valid_in),
        .ready_out      (ready_out),
        .phv_out        (phv_out),
        .phv_valid_out  (phv_valid_out),
        .key_out_masked (key_out_masked),
        .key_mask_out   (key_mask_out),
        .key_valid_out  (key_valid_out),
        .ready_in       (ready_in),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack)
    );

    key_extract_checker u_chk (
        .clk            (clk),
        .rst_n          (rst_n),
        .phv_in         (phv_in),
        .phv_valid_in   (phv_valid_in),
        .ready_out      (ready_out),
        .phv_out        (phv_out),
        .phv_valid_out  (phv_valid_out),
        .key_out_masked (key_out_masked),
        .key_mask_out   (key_mask_out),
        .key_valid_out  (key_valid_out),
        .ready_in       (ready_in),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_ack         (wb_ack),
        .wb_dat_r       (wb_dat_r),
        .off_shadow     (off_shadow),
        .mask_shadow    (mask_shadow),
        .mismatches     (mismatches),
        .protocol_errs  (protocol_errs),
        .checked        (checked)
    );

    always #10 clk = ~clk;

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic rand_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    function automatic phv_t rand_phv(input logic [3:0] tn);
        logic [`KE_PHV_W-1:0] v;
        for (int i = 0; i < `KE_PHV_W; i += 32) begin
            v[i +: 32] = rand_bits(32);
        end
        v[`KE_TENANT_LSB +: 4] = tn;
        return phv_t'(v);
    endfunction

    function automatic mask_entry_t rand_mask();
        logic [`KE_MASK_WORDS*32-1:0] v;
        for (int i = 0; i < `KE_MASK_WORDS; i++) begin
            v[i*32 +: 32] = rand_bits(32);
        end
        return mask_entry_t'(v[`KE_KEY_W-1:0]);
    endfunction

    // form 0 immediate, 1..3 the 6, 4 and 2 byte classes, 4 the zero class
    function automatic cmp_operand_t make_operand(input int form, input bit zero_imm);
        cmp_operand_t o;
        logic [1:0]   cls;
        cls = (form == 1) ? 2'd2 : (form == 2) ? 2'd1 : (form == 3) ? 2'd0 : 2'd3;
        o.is_imm = (form == 0);
        if (form == 0) begin
            o.val = zero_imm ? 8'h00 : op_byte_t'(rand_bits(8));
        end else begin
            o.val = {3'b000, cls, 3'(rand_bits(3))};
        end
        return o;
    endfunction

    function automatic off_entry_t make_offset(input int t);
        off_entry_t e;
        e.sel6_a    = sel_t'(rand_bits(3));
        e.sel6_b    = sel_t'(rand_bits(3));
        e.sel4_a    = sel_t'(rand_bits(3));
        e.sel4_b    = sel_t'(rand_bits(3));
        e.sel2_a    = sel_t'(rand_bits(3));
        e.sel2_b    = sel_t'(rand_bits(3));
        e.op.opcode = cmp_opcode_t'(t % 4);
        e.op.opa    = make_operand(t % 5, t >= 8);
        e.op.opb    = make_operand((t * 3) % 5, t >= 8);
        return e;
    endfunction

    task automatic note_timeout(input string msg);
        $display("timeout at %0t: %s", $time, msg);
        timeouts++;
        timed_out = 1;
    endtask

    task automatic wb_write(input logic [`KE_WB_AW-1:0] adr, input logic [31:0] dat);
        bit acked;
        acked = 0;
        if (timed_out) begin
            return;
        end
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = dat;
        for (int n = 0; n < ACK_LIMIT && !acked; n++) begin
            @(posedge clk);
            #1;
            acked = (wb_ack === 1'b1);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!acked) begin
            note_timeout("no wb_ack came for a table write");
        end
    endtask

    task automatic wb_read(input logic [`KE_WB_AW-1:0] adr);
        bit acked;
        acked = 0;
        if (timed_out) begin
            return;
        end
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        for (int n = 0; n < ACK_LIMIT && !acked; n++) begin
            @(posedge clk);
            #1;
            acked = (wb_ack === 1'b1);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        if (!acked) begin
            note_timeout("no wb_ack came for a table read");
        end
    endtask

    task automatic load_offset(input logic [3:0] t, input off_entry_t e);
        logic [63:0] v;
        v = {26'b0, e};
        wb_write({1'b0, t, 1'b0, 3'd0}, v[31:0]);
        wb_write({1'b0, t, 1'b0, 3'd1}, v[63:32]);
        off_shadow[t] = e;
    endtask

    task automatic load_mask(input logic [3:0] t, input mask_entry_t m);
        logic [`KE_MASK_WORDS*32-1:0] v;
        v = {31'b0, m};
        for (int w = 0; w < `KE_MASK_WORDS; w++) begin
            wb_write({1'b1, t, 1'b0, 3'(w)}, v[w*32 +: 32]);
        end
        mask_shadow[t] = m;
    endtask

    // one PHV through the stage, held for a number of cycles before the handoff
    task automatic run_item(input phv_t phv, input int hold);
        bit done;
        done = 0;
        if (timed_out) begin
            return;
        end
        phv_in       = phv;
        phv_valid_in = 1'b1;
        ready_in     = 1'b0;
        for (int n = 0; n < ACCEPT_LIMIT && !done; n++) begin
            done = (ready_out === 1'b1);
            @(posedge clk);
            #1;
        end
        if (!done) begin
            note_timeout("the PHV was never accepted");
            return;
        end
        // a decoy stays valid while the stage is busy
        phv_in = rand_phv(4'(rand_bits(4)));
        done   = 0;
        for (int n = 0; n < VALID_LIMIT && !done; n++) begin
            @(posedge clk);
            #1;
            done = (phv_valid_out === 1'b1);
        end
        if (!done) begin
            note_timeout("the output valids never rose");
            return;
        end
        for (int n = 0; n < hold; n++) begin
            @(posedge clk);
            #1;
        end
        ready_in = 1'b1;
        @(posedge clk);
        #1;
        ready_in     = 1'b0;
        phv_valid_in = 1'b0;
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        phv_in       = '0;
        phv_valid_in = 1'b0;
        ready_in     = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        off_shadow   = '0;
        mask_shadow  = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        // random selectors and operands, no masking yet
        for (int t = 0; t < `KE_TBL_DEPTH; t++) begin
            load_offset(4'(t), make_offset(t));
            load_mask(4'(t), '0);
        end
        // tables read back as zero
        wb_read({1'b0, 4'd3, 1'b0, 3'd1});
        wb_read({1'b1, 4'd12, 1'b0, 3'd6});
        for (int i = 0; i < ITEMS; i++) begin
            run_item(rand_phv(4'(i)), 0);
        end
        for (int t = 0; t < `KE_TBL_DEPTH; t++) begin
            load_mask(4'(t), rand_mask());
        end
        // random back-pressure on the output side
        for (int i = 0; i < ITEMS; i++) begin
            run_item(rand_phv(4'(rand_bits(4))), int'(rand_bits(3)));
        end
        repeat (4) @(posedge clk);
        $display("closing: %0d keys checked, %0d mismatches, %0d protocol errors, %0d timeouts",
                 checked, mismatches, protocol_errs, timeouts);
        if (mismatches == 0 && protocol_errs == 0 && timeouts == 0 && checked > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
key_extract_pkg.sv
key_extract_if.sv
table_ram.sv
wb_table_port.sv
key_extract_fsm.sv
key_builder.sv
key_extract.sv
key_extract_checker.sv
tb_key_extract.sv

//--- Bender.yml
package:
  name: key_extract

sources:
  - include_dirs:
      - .
    files:
      - key_extract_pkg.sv
      - key_extract_if.sv
      - table_ram.sv
      - wb_table_port.sv
      - key_extract_fsm.sv
      - key_builder.sv
      - key_extract.sv
  - target: test
    include_dirs:
      - .
    files:
      - key_extract_checker.sv
      - tb_key_extract.sv
